//--- vlog.f
+incdir+hw
hw/core_types_pkg.sv
hw/mem_types_pkg.sv
hw/lsq.sv
hw/int_alu.sv
hw/dcache.sv
hw/cdb_arbiter.sv
hw/lsq_subsystem.sv
bench/lsq_tb.sv

//--- Bender.yml
package:
  name: lsq_subsystem

sources:
  - include_dirs:
      - hw
    files:
      - hw/core_types_pkg.sv
      - hw/mem_types_pkg.sv
      - hw/lsq.sv
      - hw/int_alu.sv
      - hw/dcache.sv
      - hw/cdb_arbiter.sv
      - hw/lsq_subsystem.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/lsq_tb.sv

//--- bench/lsq_tb.sv
`timescale 1ns/1ps
`include "lsq_settings.svh"

module lsq_tb
    import core_types_pkg::*, mem_types_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT = 40;
    // per-test cycle budgets, summed for the watchdog
    localparam int BUDGET = 100 + 100 + 200 + 200 + 150 + 300;

    logic        clk;
    logic        reset;
    lsq_issue_t  lsq_in;
    alu_issue_t  alu_in;
    logic        retire_valid;
    rob_tag_t    retire_tag;
    cdb_packet_t cdb;
    logic        store_ready;
    rob_tag_t    store_ready_tag;
    logic        lsq_free;
    logic        alu_ready;

    // mirror of the backing memory, indexed by address bits 9 to 2
    word_t ref_mem [`DCACHE_WORDS];
    // lines already brought into the cache, by address bits 9 to 3
    logic [127:0] touched;
    word_t t4_addr [`LSQ_DEPTH];
    int seen_cnt [32];
    word_t seen_val [32];
    int errors;
    int checks;
    int seed;

    lsq_subsystem dut (.*);

    always #10 clk = ~clk;

    // cdb only comes from flops, so its value at the edge is the whole cycle's
    always @(posedge clk) begin
        if (!reset && cdb.valid) begin
            seen_cnt[cdb.tag] <= seen_cnt[cdb.tag] + 1;
            seen_val[cdb.tag] <= cdb.value;
        end
    end

    initial begin
        repeat (RESET_CYCLES + BUDGET) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", RESET_CYCLES + BUDGET);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic word_t alu_expect(alu_func_t f, word_t a, word_t b);
        case (f)
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            default: return a + b;
        endcase
    endfunction

    // word aligned, inside the 256-word backing memory
    function automatic word_t rand_addr();
        word_t r;
        r = $random(seed);
        return {22'h0, r[9:2], 2'b00};
    endfunction

    task automatic check_value(string name, word_t expected, word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic clear_seen();
        for (int i = 0; i < 32; i++) begin
            seen_cnt[i] = 0;
        end
    endtask

    // all driving tasks start and end on a falling edge
    task automatic issue_entry(logic is_store, rob_tag_t tag, logic data_valid, word_t data);
        while (!lsq_free) @(negedge clk);
        lsq_in.valid = 1'b1;
        lsq_in.is_store = is_store;
        lsq_in.rob_tag = tag;
        lsq_in.store_data_tag = tag + 5'd1;
        lsq_in.store_data_valid = data_valid;
        lsq_in.store_data = data;
        @(negedge clk);
        lsq_in.valid = 1'b0;
    endtask

    task automatic send_alu(alu_func_t f, word_t a, word_t b, rob_tag_t tag);
        alu_in.valid = 1'b1;
        alu_in.func = f;
        alu_in.opa = a;
        alu_in.opb = b;
        alu_in.rob_tag = tag;
        // held until the arbiter lets the integer unit take it
        while (!alu_ready) @(negedge clk);
        @(negedge clk);
        alu_in.valid = 1'b0;
    endtask

    // address as base plus offset through the agu
    task automatic send_addr(rob_tag_t tag, word_t addr);
        send_alu(alu_agu, addr - 32'd16, 32'd16, tag);
    endtask

    task automatic retire(rob_tag_t tag);
        retire_valid = 1'b1;
        retire_tag = tag;
        @(negedge clk);
        retire_valid = 1'b0;
    endtask

    task automatic do_load(rob_tag_t tag, word_t addr);
        issue_entry(1'b0, tag, 1'b0, '0);
        send_addr(tag, addr);
        touched[addr[9:3]] = 1'b1;
    endtask

    task automatic do_store(rob_tag_t tag, word_t addr, word_t data);
        issue_entry(1'b1, tag, 1'b1, data);
        send_addr(tag, addr);
        retire(tag);
        ref_mem[addr[9:2]] = data;
    endtask

    task automatic expect_result(string name, rob_tag_t tag, word_t expected);
        int n;
        n = 0;
        while (seen_cnt[tag] == 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (seen_cnt[tag] == 0) begin
            errors++;
            $display("test %s: no CDB result for tag %0d within %0d cycles",
                     name, tag, WAIT_LIMIT);
        end else begin
            check_value(name, expected, seen_val[tag]);
        end
    endtask

    task automatic report_test(string name, int start_errors);
        $display("test %s finished with %0d errors", name, errors - start_errors);
    endtask

    // store data comes from an integer result on the producer tag
    task automatic test_store_load();
        int e0;
        word_t addr;
        word_t data;
        e0 = errors;
        // idle state right after reset
        check_value("store_load", 32'd0, 32'(cdb.valid));
        check_value("store_load", 32'd0, 32'(store_ready));
        check_value("store_load", 32'd1, 32'(lsq_free));
        check_value("store_load", 32'd1, 32'(alu_ready));
        clear_seen();
        addr = rand_addr();
        data = $random(seed);
        issue_entry(1'b1, 5'd1, 1'b0, '0);
        send_addr(5'd1, addr);
        send_alu(alu_add, data, 32'd0, 5'd2);
        retire(5'd1);
        ref_mem[addr[9:2]] = data;
        do_load(5'd3, addr);
        expect_result("store_load", 5'd3, data);
        report_test("store_load", e0);
    endtask

    task automatic test_miss_hit();
        int e0;
        word_t addr;
        e0 = errors;
        clear_seen();
        addr = rand_addr();
        while (touched[addr[9:3]]) addr = rand_addr();
        // write-through without allocate, the line stays cold for the first load
        do_store(5'd24, addr, $random(seed));
        do_store(5'd25, addr ^ 32'd4, $random(seed));
        do_load(5'd4, addr);
        do_load(5'd5, addr ^ 32'd4);
        expect_result("miss_hit", 5'd4, ref_mem[addr[9:2]]);
        expect_result("miss_hit", 5'd5, ref_mem[addr[9:2] ^ 8'd1]);
        report_test("miss_hit", e0);
    endtask

    task automatic test_store_retire();
        int e0;
        int n;
        word_t addr;
        word_t data;
        e0 = errors;
        clear_seen();
        addr = rand_addr();
        data = $random(seed);
        // older load sees the old word
        do_load(5'd6, addr);
        expect_result("store_retire", 5'd6, ref_mem[addr[9:2]]);
        issue_entry(1'b1, 5'd7, 1'b1, data);
        send_addr(5'd7, addr);
        n = 0;
        while (!store_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!store_ready) begin
            errors++;
            $display("test store_retire: store_ready never rose for the waiting store");
        end
        check_value("store_retire", 32'd7, 32'(store_ready_tag));
        // younger load is stuck behind the unretired store
        do_load(5'd8, addr);
        repeat (20) @(negedge clk);
        check_value("store_retire", 32'd0, 32'(seen_cnt[8]));
        check_value("store_retire", 32'd1, 32'(store_ready));
        retire(5'd7);
        ref_mem[addr[9:2]] = data;
        expect_result("store_retire", 5'd8, data);
        do_load(5'd9, addr);
        expect_result("store_retire", 5'd9, data);
        report_test("store_retire", e0);
    endtask

    task automatic test_queue_full();
        int e0;
        e0 = errors;
        clear_seen();
        for (int i = 0; i < `LSQ_DEPTH - 1; i++) begin
            t4_addr[i] = rand_addr();
            issue_entry(1'b0, rob_tag_t'(10 + i), 1'b0, '0);
        end
        check_value("queue_full", 32'd0, 32'(lsq_free));
        for (int i = 0; i < `LSQ_DEPTH - 1; i++) begin
            send_addr(rob_tag_t'(10 + i), t4_addr[i]);
            touched[t4_addr[i][9:3]] = 1'b1;
        end
        for (int i = 0; i < `LSQ_DEPTH - 1; i++) begin
            expect_result("queue_full", rob_tag_t'(10 + i), ref_mem[t4_addr[i][9:2]]);
        end
        check_value("queue_full", 32'd1, 32'(lsq_free));
        report_test("queue_full", e0);
    endtask

    // agu and integer ops interleaved so load results meet integer results
    task automatic test_cdb_contention();
        int e0;
        word_t a;
        word_t b;
        word_t exp_val [8];
        alu_func_t f;
        e0 = errors;
        clear_seen();
        for (int i = 0; i < 4; i++) begin
            issue_entry(1'b0, rob_tag_t'(17 + i), 1'b0, '0);
        end
        for (int i = 0; i < 8; i++) begin
            if (i < 4) begin
                send_addr(rob_tag_t'(17 + i), t4_addr[i]);
            end
            a = $random(seed);
            b = $random(seed);
            f = alu_func_t'(i % 5);
            exp_val[i] = alu_expect(f, a, b);
            send_alu(f, a, b, rob_tag_t'(21 + i));
        end
        for (int i = 0; i < 4; i++) begin
            expect_result("cdb_contention", rob_tag_t'(17 + i), ref_mem[t4_addr[i][9:2]]);
        end
        for (int i = 0; i < 8; i++) begin
            expect_result("cdb_contention", rob_tag_t'(21 + i), exp_val[i]);
        end
        repeat (10) @(negedge clk);
        for (int t = 17; t < 29; t++) begin
            check_value("cdb_contention", 32'd1, 32'(seen_cnt[t]));
        end
        // slot drained, integer unit free again
        check_value("cdb_contention", 32'd1, 32'(alu_ready));
        report_test("cdb_contention", e0);
    endtask

    task automatic test_word_lanes();
        int e0;
        word_t base;
        rob_tag_t t;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            clear_seen();
            base = rand_addr() & ~32'd4;
            t = rob_tag_t'(4 * i + 1);
            do_store(t, base, $random(seed));
            do_store(t + 5'd1, base | 32'd4, $random(seed));
            do_load(t + 5'd2, base | 32'd4);
            do_load(t + 5'd3, base);
            expect_result("word_lanes", t + 5'd2, ref_mem[base[9:2] | 8'd1]);
            expect_result("word_lanes", t + 5'd3, ref_mem[base[9:2]]);
        end
        report_test("word_lanes", e0);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        lsq_in = '0;
        alu_in = '0;
        retire_valid = 1'b0;
        retire_tag = '0;
        errors = 0;
        checks = 0;
        seed = 31;
        touched = '0;
        for (int i = 0; i < `DCACHE_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        clear_seen();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_store_load();
        test_miss_hit();
        test_store_retire();
        test_queue_full();
        test_cdb_contention();
        test_word_lanes();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- hw/lsq_subsystem.sv
`timescale 1ns/1ps

module lsq_subsystem import core_types_pkg::*, mem_types_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  lsq_issue_t  lsq_in,
    input  alu_issue_t  alu_in,
    input  logic        retire_valid,
    input  rob_tag_t    retire_tag,
    output cdb_packet_t cdb,
    output logic        store_ready,
    output rob_tag_t    store_ready_tag,
    output logic        lsq_free,
    output logic        alu_ready
);

    priv_addr_t  priv_addr;
    cdb_packet_t alu_result;
    cdb_packet_t lsq_result;
    dcache_req_t dcache_req;
    dcache_rsp_t dcache_rsp;

    // merged bus also feeds store data back into the queue
    lsq u_lsq (
        .clk             (clk),
        .reset           (reset),
        .issue           (lsq_in),
        .priv_addr       (priv_addr),
        .cdb_in          (cdb),
        .retire_valid    (retire_valid),
        .retire_tag      (retire_tag),
        .dcache_rsp      (dcache_rsp),
        .dcache_req      (dcache_req),
        .result          (lsq_result),
        .store_ready     (store_ready),
        .store_ready_tag (store_ready_tag),
        .lsq_free        (lsq_free)
    );

    int_alu u_alu (
        .clk       (clk),
        .reset     (reset),
        .issue     (alu_in),
        .ready     (alu_ready),
        .result    (alu_result),
        .priv_addr (priv_addr)
    );

    dcache u_dcache (
        .clk   (clk),
        .reset (reset),
        .req   (dcache_req),
        .rsp   (dcache_rsp)
    );

    cdb_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .lsq_result (lsq_result),
        .alu_result (alu_result),
        .cdb        (cdb),
        .alu_ready  (alu_ready)
    );

endmodule

//--- hw/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter import core_types_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  cdb_packet_t lsq_result,
    input  cdb_packet_t alu_result,
    output cdb_packet_t cdb,
    output logic        alu_ready
);

    // parked integer result
    cdb_packet_t slot;
    logic park;

    // integer result loses to a queue result
    assign park = alu_result.valid && lsq_result.valid;

    // hold the integer unit while the slot is full or filling
    assign alu_ready = !slot.valid && !park;

    always_comb begin
        if (lsq_result.valid) begin
            cdb = lsq_result;
        end else if (slot.valid) begin
            cdb = slot;
        end else begin
            cdb = alu_result;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot <= '0;
        end else if (park) begin
            slot <= alu_result;
        end else if (slot.valid && !lsq_result.valid) begin
            // drained onto the bus this cycle
            slot.valid <= 1'b0;
        end
    end

    // the integer unit must honour alu_ready
    assert property (@(posedge clk) disable iff (reset) slot.valid |-> !alu_result.valid);

endmodule

//--- hw/dcache.sv
`timescale 1ns/1ps
`include "lsq_settings.svh"

module dcache import core_types_pkg::*, mem_types_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  dcache_req_t req,
    output dcache_rsp_t rsp
);

    localparam int IDX_W = $clog2(`DCACHE_LINES);
    localparam int WORD_AW = $clog2(`DCACHE_WORDS);
    localparam int CNT_W = $clog2(`DCACHE_MISS_CYCLES + 1);

    word_t mem [`DCACHE_WORDS];
    logic [31:IDX_W+3] tag_arr [`DCACHE_LINES];
    logic [`DCACHE_LINES-1:0] line_valid;
    logic busy, accept, line_hit, done, miss_start;
    logic [CNT_W-1:0] count;
    cache_tag_t next_tag, miss_tag;
    word_t miss_addr, look_addr;
    logic [IDX_W-1:0] idx, miss_idx;
    logic [WORD_AW-2:0] line_word;

    // backing memory starts cleared
    initial begin
        for (int i = 0; i < `DCACHE_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign idx = req.addr[IDX_W+2:3];
    assign miss_idx = miss_addr[IDX_W+2:3];
    assign line_hit = line_valid[idx] && (tag_arr[idx] == req.addr[31:IDX_W+3]);
    // only one access at a time, a miss blocks everything
    assign accept = !busy && (req.cmd != cmd_none);
    assign miss_start = accept && (req.cmd == cmd_load) && !line_hit;
    assign done = busy && (count == '0);
    // line data follows the miss while busy, else the request
    assign look_addr = busy ? miss_addr : req.addr;
    assign line_word = look_addr[WORD_AW+1:3];

    always_comb begin
        rsp.response = accept ? next_tag : '0;
        rsp.hit = accept && line_hit;
        rsp.done_tag = done ? miss_tag : '0;
        rsp.data = {mem[{line_word, 1'b1}], mem[{line_word, 1'b0}]};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            count <= '0;
            next_tag <= cache_tag_t'(1);
            miss_tag <= '0;
            miss_addr <= '0;
            line_valid <= '0;
        end else begin
            // accept tags run 1 to 15 and skip zero
            if (accept) begin
                next_tag <= (next_tag == '1) ? cache_tag_t'(1) : next_tag + 1'b1;
            end
            if (miss_start) begin
                busy <= 1'b1;
                count <= CNT_W'(`DCACHE_MISS_CYCLES - 1);
                miss_tag <= next_tag;
                miss_addr <= req.addr;
            end else if (done) begin
                busy <= 1'b0;
                line_valid[miss_idx] <= 1'b1;
            end else if (busy) begin
                count <= count - 1'b1;
            end
        end
    end

    // line fill
    always_ff @(posedge clk) begin
        if (done) begin
            tag_arr[miss_idx] <= miss_addr[31:IDX_W+3];
        end
    end

    // write-through, one word lane per store
    always @(posedge clk) begin
        if (accept && (req.cmd == cmd_store)) begin
            mem[req.addr[WORD_AW+1:2]] <= req.addr[2] ? req.data[63:32] : req.data[31:0];
        end
    end

    // completion lands exactly the miss latency after its accept
    assert property (@(posedge clk) disable iff (reset)
        (rsp.done_tag != '0) |-> $past(miss_start, `DCACHE_MISS_CYCLES));

endmodule

//--- hw/int_alu.sv
`timescale 1ns/1ps

module int_alu import core_types_pkg::*, mem_types_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  alu_issue_t  issue,
    input  logic        ready,
    output cdb_packet_t result,
    output priv_addr_t  priv_addr
);

    logic  take;
    word_t value;

    // arbiter back-pressure, nothing is taken while ready is low
    assign take = issue.valid && ready;

    always_comb begin
        case (issue.func)
            alu_sub: value = issue.opa - issue.opb;
            alu_and: value = issue.opa & issue.opb;
            alu_or:  value = issue.opa | issue.opb;
            alu_xor: value = issue.opa ^ issue.opb;
            // add and agu share the adder
            default: value = issue.opa + issue.opb;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
            priv_addr <= '0;
        end else begin
            // agu goes to the queue, everything else toward the CDB
            result.valid <= take && (issue.func != alu_agu);
            result.tag <= issue.rob_tag;
            result.value <= value;
            priv_addr.valid <= take && (issue.func == alu_agu);
            priv_addr.tag <= issue.rob_tag;
            priv_addr.addr <= value;
        end
    end

endmodule

//--- hw/lsq.sv
`timescale 1ns/1ps
`include "lsq_settings.svh"

module lsq import core_types_pkg::*, mem_types_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  lsq_issue_t  issue,
    input  priv_addr_t  priv_addr,
    input  cdb_packet_t cdb_in,
    input  logic        retire_valid,
    input  rob_tag_t    retire_tag,
    input  dcache_rsp_t dcache_rsp,
    output dcache_req_t dcache_req,
    output cdb_packet_t result,
    output logic        store_ready,
    output rob_tag_t    store_ready_tag,
    output logic        lsq_free
);

    localparam int IDX_W = `LSQ_PTR_W - 1;

    lsq_entry_t q [`LSQ_DEPTH];
    logic [`LSQ_PTR_W-1:0] head, tail, count;
    logic [IDX_W-1:0] head_idx, tail_idx;
    lsq_entry_t head_e, new_e;
    logic full, enq, head_ready, accepted, hit_done, load_done, pop;
    // single outstanding miss
    logic in_flight, flight_lane;
    cache_tag_t flight_tag;

    function automatic word_t pick_lane(line_t line, logic upper);
        return upper ? line[63:32] : line[31:0];
    endfunction

    assign head_idx = head[IDX_W-1:0];
    assign tail_idx = tail[IDX_W-1:0];
    assign count = tail - head;
    assign full = (count == `LSQ_DEPTH);
    // drops one entry early so an issue launched in the same cycle still fits
    assign lsq_free = (count < `LSQ_DEPTH - 1);
    assign enq = issue.valid && !full;

    assign head_e = q[head_idx];

    // loads need an address, stores also need data and the retire mark
    assign head_ready = head_e.valid && head_e.address_valid && !in_flight &&
                        (!head_e.is_store || (head_e.store_data_valid && head_e.retired));

    // tell the retire stage the oldest store only waits on retirement
    assign store_ready = head_e.valid && head_e.is_store && head_e.address_valid &&
                         head_e.store_data_valid && !head_e.retired;
    assign store_ready_tag = head_e.rob_tag;

    always_comb begin
        dcache_req.cmd = cmd_none;
        dcache_req.addr = head_e.address;
        // store word goes into the lane picked by address bit 2
        dcache_req.data = head_e.address[2] ? {head_e.store_data, 32'h0}
                                            : {32'h0, head_e.store_data};
        if (head_ready) begin
            dcache_req.cmd = head_e.is_store ? cmd_store : cmd_load;
        end
    end

    // cache takes the command when it answers with a tag
    assign accepted = (dcache_req.cmd != cmd_none) && (dcache_rsp.response != '0);
    assign hit_done = accepted && !head_e.is_store && dcache_rsp.hit;
    assign load_done = in_flight && (dcache_rsp.done_tag == flight_tag);
    // stores leave on accept, loads on hit or miss completion
    assign pop = (accepted && head_e.is_store) || hit_done || load_done;

    // new entry, catching an address or data that shows up in the enqueue cycle
    always_comb begin
        new_e = '0;
        new_e.valid = 1'b1;
        new_e.is_store = issue.is_store;
        new_e.rob_tag = issue.rob_tag;
        new_e.address = priv_addr.addr;
        new_e.address_valid = priv_addr.valid && (priv_addr.tag == issue.rob_tag);
        new_e.store_data_tag = issue.store_data_tag;
        new_e.store_data = issue.store_data;
        new_e.store_data_valid = issue.store_data_valid;
        if (issue.is_store && !issue.store_data_valid && cdb_in.valid &&
            (cdb_in.tag == issue.store_data_tag)) begin
            new_e.store_data = cdb_in.value;
            new_e.store_data_valid = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            in_flight <= 1'b0;
            flight_lane <= 1'b0;
            flight_tag <= '0;
            result <= '0;
            for (int i = 0; i < `LSQ_DEPTH; i++) begin
                q[i] <= '0;
            end
        end else begin
            // result pulses for one cycle
            result.valid <= 1'b0;

            // miss accepted, hold the head until done_tag comes back
            if (accepted && !head_e.is_store && !dcache_rsp.hit) begin
                in_flight <= 1'b1;
                flight_tag <= dcache_rsp.response;
                flight_lane <= head_e.address[2];
            end
            if (hit_done) begin
                result.valid <= 1'b1;
                result.tag <= head_e.rob_tag;
                result.value <= pick_lane(dcache_rsp.data, head_e.address[2]);
            end
            if (load_done) begin
                in_flight <= 1'b0;
                result.valid <= 1'b1;
                result.tag <= head_e.rob_tag;
                result.value <= pick_lane(dcache_rsp.data, flight_lane);
            end
            if (pop) begin
                q[head_idx].valid <= 1'b0;
                head <= head + 1'b1;
            end

            // parallel search on address channel, CDB and retire tag
            for (int i = 0; i < `LSQ_DEPTH; i++) begin
                if (priv_addr.valid && q[i].valid && !q[i].address_valid &&
                    (q[i].rob_tag == priv_addr.tag)) begin
                    q[i].address <= priv_addr.addr;
                    q[i].address_valid <= 1'b1;
                end
                if (cdb_in.valid && q[i].valid && q[i].is_store &&
                    !q[i].store_data_valid && (q[i].store_data_tag == cdb_in.tag)) begin
                    q[i].store_data <= cdb_in.value;
                    q[i].store_data_valid <= 1'b1;
                end
                if (retire_valid && q[i].valid && q[i].is_store &&
                    (q[i].rob_tag == retire_tag)) begin
                    q[i].retired <= 1'b1;
                end
            end

            if (enq) begin
                q[tail_idx] <= new_e;
                tail <= tail + 1'b1;
            end
        end
    end

    // the issuing side must watch lsq_free
    assert property (@(posedge clk) disable iff (reset) issue.valid |-> !full);

    // cache never answers a command that was not driven
    assert property (@(posedge clk) disable iff (reset)
        (dcache_rsp.response != '0) |-> (dcache_req.cmd != cmd_none));

endmodule

//--- hw/mem_types_pkg.sv
package mem_types_pkg;

    import core_types_pkg::*;

    // two-word cache line, address bit 2 picks the upper word
    typedef logic [63:0] line_t;

    // cache transaction tag, zero means none
    typedef logic [3:0] cache_tag_t;

    typedef enum logic [1:0] {
        cmd_none,
        cmd_load,
        cmd_store
    } cache_cmd_t;

    // load or store entering the queue
    typedef struct packed {
        logic     valid;
        logic     is_store;
        rob_tag_t rob_tag;
        rob_tag_t store_data_tag;
        logic     store_data_valid;
        word_t    store_data;
    } lsq_issue_t;

    // address from the integer unit, only the queue listens
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    addr;
    } priv_addr_t;

    typedef struct packed {
        logic     valid;
        logic     is_store;
        rob_tag_t rob_tag;
        word_t    address;
        logic     address_valid;
        word_t    store_data;
        rob_tag_t store_data_tag;
        logic     store_data_valid;
        logic     retired;
    } lsq_entry_t;

    typedef struct packed {
        cache_cmd_t cmd;
        word_t      addr;
        line_t      data;
    } dcache_req_t;

    typedef struct packed {
        cache_tag_t response;
        logic       hit;
        cache_tag_t done_tag;
        line_t      data;
    } dcache_rsp_t;

endpackage

//--- hw/core_types_pkg.sv
package core_types_pkg;

    // reorder buffer tag, also names a store-data producer
    typedef logic [4:0] rob_tag_t;

    // data or address word
    typedef logic [31:0] word_t;

    // one broadcast on the common data bus
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_packet_t;

    // integer unit functions
    // agu adds like alu_add but its result goes to the private address channel
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_agu
    } alu_func_t;

    // issue packet into the integer unit
    typedef struct packed {
        logic      valid;
        word_t     opa;
        word_t     opb;
        alu_func_t func;
        rob_tag_t  rob_tag;
    } alu_issue_t;

endpackage

//--- hw/lsq_settings.svh
`ifndef LSQ_SETTINGS_SVH
`define LSQ_SETTINGS_SVH

// queue entries, a power of two
`define LSQ_DEPTH 8
// head and tail pointers carry one extra wrap bit
`define LSQ_PTR_W ($clog2(`LSQ_DEPTH) + 1)

// direct-mapped lines, indexed by address bits 6 to 3
`define DCACHE_LINES 16
// cycles from miss accept to done_tag
`define DCACHE_MISS_CYCLES 6
// backing memory size in words
`define DCACHE_WORDS 256

`endif
